//--- src/stream_pkg.sv
// shared constants and types for the byte stream pipeline.
// every block reaches these through scoped names, stream_pkg::name.

`default_nettype none

package stream_pkg;

	//////////////////////////////////////////////////////////////
	// stream data path.
	//////////////////////////////////////////////////////////////

	// bits per stream item.
	localparam int data_width = 8;

	//////////////////////////////////////////////////////////////
	// fifo sizing.
	//////////////////////////////////////////////////////////////

	// number of fifo entries, output word included.
	localparam int fifo_depth = 4;

	// occupancy count, must hold 0 up to fifo_depth.
	localparam int level_width = 3;

	//////////////////////////////////////////////////////////////
	// throttle and pipeline.
	//////////////////////////////////////////////////////////////

	// cycles per throttle window, the last one is open.
	localparam int throttle_period = 3;

	// items held with the output stalled.
	// two in the register slice, the rest in the fifo.
	localparam int pipe_capacity = 2 + fifo_depth;

	//////////////////////////////////////////////////////////////
	// source selection.
	//////////////////////////////////////////////////////////////

	// where the stream items come from.
	typedef enum logic
	{
		mode_push  = 1'b0, // external push interface.
		mode_count = 1'b1  // internal up-counter.
	} source_mode_t;

endpackage

`default_nettype wire

//--- src/stream_source.sv
// head of the pipeline, picks the push interface or the counter.
// a push that finds the stream busy is lost and sets the sticky error.

`timescale 1ns/1ps
`default_nettype none

module stream_source
(
	input  wire                               clock,
	input  wire                               resetn,
	input  stream_pkg::source_mode_t          mode,
	input  wire [stream_pkg::data_width-1:0]  push_data,
	input  wire                               push_enable,
	output logic [stream_pkg::data_width-1:0] src_data,
	output logic                              src_valid,
	input  wire                               src_ready,
	output logic                              error
);

	logic [stream_pkg::data_width-1:0] count; // pattern generator state.
	logic                              push_mode; // decoded mode.
	logic                              count_step; // counter item accepted.
	logic                              overflow; // push refused this cycle.

	//////////////////////////////////////////////////////////////
	// mode decode and stream select.
	//////////////////////////////////////////////////////////////

	assign push_mode = (mode == stream_pkg::mode_push);

	always_comb
	begin
		if (push_mode)
		begin
			src_valid = push_enable; // one item per enable.
			src_data  = push_data;
		end
		else
		begin
			src_valid = 1'b1; // counter always has an item.
			src_data  = count;
		end
	end

	//////////////////////////////////////////////////////////////
	// counter pattern.
	//////////////////////////////////////////////////////////////

	// moves only on an accepted transfer in counter mode.
	assign count_step = !push_mode && src_ready;

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			count <= '0;
		else if (count_step)
			count <= count + 1'b1; // wraps at 256.
	end

	//////////////////////////////////////////////////////////////
	// overflow flag.
	//////////////////////////////////////////////////////////////

	// push has no ready, so a busy stream drops the item.
	assign overflow = push_mode && push_enable && !src_ready;

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			error <= 1'b0;
		else if (overflow)
			error <= 1'b1; // held until reset.
	end

endmodule

`default_nettype wire

//--- src/stream_register_slice.sv
// two-entry skid register. data, valid and ready all leave a flop,
// so it cuts every combinational path through the stream.

`timescale 1ns/1ps
`default_nettype none

module stream_register_slice
(
	input  wire                               clock,
	input  wire                               resetn,
	input  wire [stream_pkg::data_width-1:0]  idata,
	input  wire                               ivalid,
	output logic                              iready,
	output logic [stream_pkg::data_width-1:0] odata,
	output logic                              ovalid,
	input  wire                               oready
);

	// iready  && !ovalid : both registers empty.
	// iready  &&  ovalid : output full, skid empty.
	// !iready &&  ovalid : output and skid full.
	// !iready && !ovalid never occurs.

	logic [stream_pkg::data_width-1:0] skid; // extra item under stall.
	logic                              hold; // output item not taken.

	assign hold = ovalid && !oready;

	//////////////////////////////////////////////////////////////
	// control flops.
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			ovalid <= 1'b0;
			iready <= 1'b1; // empty, ready from the start.
		end
		else
		begin
			ovalid <= hold || !iready || ivalid; // stalled, skid or new item.
			iready <= !ovalid || oready || (iready && !ivalid);
		end
	end

	//////////////////////////////////////////////////////////////
	// payload flops.
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (!hold)
			odata <= iready ? idata : skid; // skid item goes first.
	end

	// capture the input while the skid is free.
	// it only counts as stored when the output stalls.
	always_ff @(posedge clock)
	begin
		if (iready || oready)
			skid <= idata;
	end

endmodule

`default_nettype wire

//--- src/stream_fifo.sv
// small shift-register fifo with a registered output word.
// level reports the items held, output word included.
// iready and ovalid come from flops and follow the count.

`timescale 1ns/1ps
`default_nettype none

module stream_fifo
(
	input  wire                                clock,
	input  wire                                resetn,
	input  wire [stream_pkg::data_width-1:0]   idata,
	input  wire                                ivalid,
	output logic                               iready,
	output logic [stream_pkg::data_width-1:0]  odata,
	output logic                               ovalid,
	input  wire                                oready,
	output logic [stream_pkg::level_width-1:0] level
);

	logic itransfer; // item taken at the input.
	logic otransfer; // item taken at the output.

	logic [stream_pkg::level_width-1:0] level_after_out; // count after output.
	logic [stream_pkg::level_width-1:0] level_next; // count after both.

	// newest item at entry 1, entry i is the i-th most recent.
	// the oldest of a full fifo lives only in odata.
	logic [stream_pkg::data_width-1:0] shift [1:stream_pkg::fifo_depth-1];
	logic [stream_pkg::data_width-1:0] odata_next; // selected next word.

	assign itransfer = ivalid && iready;
	assign otransfer = ovalid && oready;

	//////////////////////////////////////////////////////////////
	// occupancy.
	//////////////////////////////////////////////////////////////

	always_comb
	begin
		level_after_out = otransfer ? level - 1'b1 : level;
		level_next      = itransfer ? level_after_out + 1'b1 : level_after_out;
	end

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			level  <= '0;
			iready <= 1'b0; // rises one cycle after reset.
			ovalid <= 1'b0;
		end
		else
		begin
			level  <= level_next;
			iready <= (level_next < stream_pkg::fifo_depth); // room left.
			ovalid <= (level_next != '0); // something to show.
		end
	end

	//////////////////////////////////////////////////////////////
	// storage.
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (itransfer)
		begin
			shift[1] <= idata;
			for (int i = 2; i < stream_pkg::fifo_depth; i++)
				shift[i] <= shift[i-1]; // age by one.
		end
	end

	// the next output is the oldest item left after the output move.
	// an empty fifo passes the arriving item straight through.
	always_comb
	begin
		odata_next = odata; // full fifo keeps its word.
		if (level_after_out == '0)
			odata_next = idata;
		for (int i = 1; i < stream_pkg::fifo_depth; i++)
		begin
			if (level_after_out == i)
				odata_next = shift[i];
		end
	end

	always_ff @(posedge clock)
	begin
		odata <= odata_next;
	end

endmodule

`default_nettype wire

//--- src/stream_throttle.sv
// rate limiter, opens the stream for one cycle per window.
// data passes through, only valid and ready are gated.

`timescale 1ns/1ps
`default_nettype none

module stream_throttle
(
	input  wire                               clock,
	input  wire                               resetn,
	input  wire [stream_pkg::data_width-1:0]  idata,
	input  wire                               ivalid,
	output logic                              iready,
	output logic [stream_pkg::data_width-1:0] odata,
	output logic                              ovalid,
	input  wire                               oready
);

	// cycles left until the open one, zero means open.
	logic [$clog2(stream_pkg::throttle_period)-1:0] phase;
	logic                                            open;

	assign open = (phase == '0);

	//////////////////////////////////////////////////////////////
	// phase counter.
	//////////////////////////////////////////////////////////////

	// free running from reset release, first open cycle is
	// cycle throttle_period.
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			phase <= $bits(phase)'(stream_pkg::throttle_period - 1);
		else if (open)
			phase <= $bits(phase)'(stream_pkg::throttle_period - 1); // reload.
		else
			phase <= phase - 1'b1;
	end

	//////////////////////////////////////////////////////////////
	// stream gating.
	//////////////////////////////////////////////////////////////

	assign ovalid = ivalid && open; // both sides see the same window.
	assign iready = oready && open;
	assign odata  = idata;

endmodule

`default_nettype wire

//--- src/stream_pipe_top.sv
// full conditioning pipeline: source, register slice, fifo, throttle.
// only instances and the links between them live here.

`timescale 1ns/1ps
`default_nettype none

module stream_pipe_top
(
	input  wire                                clock,
	input  wire                                resetn,
	input  stream_pkg::source_mode_t           mode,
	input  wire [stream_pkg::data_width-1:0]   push_data,
	input  wire                                push_enable,
	output logic [stream_pkg::data_width-1:0]  out_data,
	output logic                               out_valid,
	input  wire                                out_ready,
	output logic                               error,
	output logic [stream_pkg::level_width-1:0] fifo_level
);

	// source to slice.
	logic [stream_pkg::data_width-1:0] src_data;
	logic                              src_valid;
	logic                              src_ready;

	// slice to fifo.
	logic [stream_pkg::data_width-1:0] reg_data;
	logic                              reg_valid;
	logic                              reg_ready;

	// fifo to throttle.
	logic [stream_pkg::data_width-1:0] fifo_data;
	logic                              fifo_valid;
	logic                              fifo_ready;

	//////////////////////////////////////////////////////////////
	// pipeline chain.
	//////////////////////////////////////////////////////////////

	stream_source u_source (
		.clock      (clock),
		.resetn     (resetn),
		.mode       (mode),
		.push_data  (push_data),
		.push_enable(push_enable),
		.src_data   (src_data),
		.src_valid  (src_valid),
		.src_ready  (src_ready),
		.error      (error)
	);

	stream_register_slice u_slice (
		.clock (clock),
		.resetn(resetn),
		.idata (src_data),
		.ivalid(src_valid),
		.iready(src_ready),
		.odata (reg_data),
		.ovalid(reg_valid),
		.oready(reg_ready)
	);

	stream_fifo u_fifo (
		.clock (clock),
		.resetn(resetn),
		.idata (reg_data),
		.ivalid(reg_valid),
		.iready(reg_ready),
		.odata (fifo_data),
		.ovalid(fifo_valid),
		.oready(fifo_ready),
		.level (fifo_level) // occupancy for status.
	);

	stream_throttle u_throttle (
		.clock (clock),
		.resetn(resetn),
		.idata (fifo_data),
		.ivalid(fifo_valid),
		.iready(fifo_ready),
		.odata (out_data),
		.ovalid(out_valid),
		.oready(out_ready)
	);

endmodule

`default_nettype wire

//--- tb/stream_pipe_tests.svh
// directed tests for the stream pipeline, one task per behavior.
// included inside the testbench module and uses its signals and helpers.

`ifndef stream_pipe_tests_svh
`define stream_pipe_tests_svh

//////////////////////////////////////////////////////////////
// reset and push mode.
//////////////////////////////////////////////////////////////

task automatic test_reset_state();
	@(posedge clock);
	check_flag("out_valid", out_valid, 1'b0);
	check_flag("error", error, 1'b0);
	check_level("fifo_level", fifo_level, '0);
endtask

// pushes land every throttle_period cycles, outputs checked as they come.
task automatic test_push_order();
	logic [stream_pkg::data_width-1:0] value;
	int pushed;
	int received;
	int idle;
	int tick;
	pushed   = 0;
	received = 0;
	idle     = 0;
	tick     = 0;
	out_ready <= 1'b1;
	while (received < push_count)
	begin
		@(posedge clock);
		if (out_valid && out_ready)
		begin
			check_data("out_data", out_data, expected_items.pop_front());
			received++;
			idle = 0;
		end
		else
		begin
			idle++;
			if (idle > transfer_timeout)
				report_failure("push mode output stopped before all items arrived");
		end
		if (pushed < push_count && tick == 0)
		begin
			random_byte(value);
			expected_items.push_back(value);
			push_data   <= value;
			push_enable <= 1'b1;
			pushed++;
		end
		else
			push_enable <= 1'b0;
		tick = (tick + 1) % stream_pkg::throttle_period;
	end
	push_enable <= 1'b0;
	check_flag("error", error, 1'b0);
endtask

//////////////////////////////////////////////////////////////
// back-pressure.
//////////////////////////////////////////////////////////////

task automatic test_back_pressure();
	logic [stream_pkg::data_width-1:0] value;
	logic [stream_pkg::data_width-1:0] seen;
	int cycles;
	out_ready <= 1'b0;
	for (int i = 0; i < stream_pkg::pipe_capacity; i++)
	begin
		random_byte(value);
		expected_items.push_back(value);
		push_byte(value);
		wait_cycles(push_gap - 1);
	end
	check_flag("error", error, 1'b0);
	check_level("fifo_level", fifo_level, stream_pkg::level_width'(stream_pkg::fifo_depth));
	random_byte(value);
	push_byte(value); // no room left, item is dropped.
	wait_cycles(1);
	check_flag("error", error, 1'b1);
	out_ready <= 1'b1;
	for (int i = 0; i < stream_pkg::pipe_capacity; i++)
	begin
		wait_transfer(seen, cycles);
		check_data("out_data", seen, expected_items.pop_front());
	end
	for (int i = 0; i < 2 * stream_pkg::throttle_period; i++)
	begin
		@(posedge clock);
		if (out_valid)
			report_failure("an item came out after the pipeline was drained");
	end
	check_level("fifo_level", fifo_level, '0);
	apply_reset();
endtask

//////////////////////////////////////////////////////////////
// counter mode.
//////////////////////////////////////////////////////////////

// counter model, the next item due at the output.
logic [stream_pkg::data_width-1:0] count_expected;

task automatic test_count_mode();
	logic [stream_pkg::data_width-1:0] coin;
	int received;
	int idle;
	count_expected = '0; // counter restarts at reset.
	received       = 0;
	idle           = 0;
	mode <= stream_pkg::mode_count;
	while (received < count_items)
	begin
		@(posedge clock);
		if (out_valid && out_ready)
		begin
			check_data("out_data", out_data, count_expected);
			count_expected = count_expected + stream_pkg::data_width'(1);
			received++;
			idle = 0;
		end
		else
		begin
			idle++;
			if (idle > transfer_timeout)
				report_failure("counter mode output stopped before all items arrived");
		end
		random_byte(coin);
		out_ready <= coin[0]; // random back-pressure.
	end
endtask

// full pipeline, transfers only on open throttle cycles.
task automatic test_throttle_spacing();
	logic [stream_pkg::data_width-1:0] seen;
	int cycles;
	out_ready <= 1'b1;
	// pipeline fills, items leaving meanwhile still follow the counter.
	for (int i = 0; i < 4 * stream_pkg::pipe_capacity; i++)
	begin
		@(posedge clock);
		if (out_valid && out_ready)
		begin
			check_data("out_data", out_data, count_expected);
			count_expected = count_expected + stream_pkg::data_width'(1);
		end
	end
	wait_transfer(seen, cycles); // first open cycle sets the phase.
	check_data("out_data", seen, count_expected);
	count_expected = count_expected + stream_pkg::data_width'(1);
	for (int i = 0; i < 10; i++)
	begin
		wait_transfer(seen, cycles);
		check_cycles("transfer spacing", cycles, stream_pkg::throttle_period);
		check_data("out_data", seen, count_expected);
		count_expected = count_expected + stream_pkg::data_width'(1);
	end
endtask

`endif

//--- tb/stream_pipe_tb.sv
// testbench top for the byte stream pipeline.
// holds clock, reset, the DUT, the random source and the compare helpers.
// the directed tests come from the included test file.

`timescale 1ns/1ps
`default_nettype none

module stream_pipe_tb;

	localparam int transfer_timeout = 60; // cycles allowed per output item.
	localparam int push_gap         = 3; // idle cycles between stalled pushes.
	localparam int push_count       = 30; // items in the push mode run.
	localparam int count_items      = 40; // items in the counter mode run.

	logic                               clock = 1'b0;
	logic                               resetn;
	stream_pkg::source_mode_t           mode;
	logic [stream_pkg::data_width-1:0]  push_data;
	logic                               push_enable;
	logic [stream_pkg::data_width-1:0]  out_data;
	logic                               out_valid;
	logic                               out_ready;
	logic                               error;
	logic [stream_pkg::level_width-1:0] fifo_level;

	logic [31:0]                       rng_state = 32'd73; // xorshift state.
	logic [stream_pkg::data_width-1:0] expected_items [$]; // pushed, not yet out.

	always #50 clock = ~clock; // 100 ns period.

	stream_pipe_top DUT (
		.clock      (clock),
		.resetn     (resetn),
		.mode       (mode),
		.push_data  (push_data),
		.push_enable(push_enable),
		.out_data   (out_data),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.error      (error),
		.fifo_level (fifo_level)
	);

	//////////////////////////////////////////////////////////////
	// random source.
	//////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic random_byte(output logic [stream_pkg::data_width-1:0] value);
		rng_state = xorshift32(rng_state);
		value     = rng_state[stream_pkg::data_width-1:0]; // low byte.
	endtask

	//////////////////////////////////////////////////////////////
	// failure reporting and compares.
	//////////////////////////////////////////////////////////////

	task automatic stop_run();
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic report_failure(input string what);
		$display("Error at %0t ns: %s", $time, what);
		stop_run();
	endtask

	task automatic check_data(input string name,
		input logic [stream_pkg::data_width-1:0] actual,
		input logic [stream_pkg::data_width-1:0] expected);
		if (actual !== expected)
		begin
			$display("Fail at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
			stop_run();
		end
	endtask

	task automatic check_flag(input string name, input logic actual, input logic expected);
		if (actual !== expected)
		begin
			$display("Fail at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
			stop_run();
		end
	endtask

	task automatic check_level(input string name,
		input logic [stream_pkg::level_width-1:0] actual,
		input logic [stream_pkg::level_width-1:0] expected);
		if (actual !== expected)
		begin
			$display("Fail at %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
			stop_run();
		end
	endtask

	task automatic check_cycles(input string name, input int actual, input int expected);
		if (actual != expected)
		begin
			$display("Fail at %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
			stop_run();
		end
	endtask

	//////////////////////////////////////////////////////////////
	// drive and wait helpers.
	//////////////////////////////////////////////////////////////

	task automatic wait_cycles(input int count);
		repeat (count) @(posedge clock);
	endtask

	// inputs back to idle, reset held for 16 cycles.
	task automatic apply_reset();
		resetn      <= 1'b0;
		mode        <= stream_pkg::mode_push;
		push_enable <= 1'b0;
		out_ready   <= 1'b0;
		wait_cycles(16);
		resetn <= 1'b1; // released on a rising edge.
	endtask

	// one push cycle, then the enable drops.
	task automatic push_byte(input logic [stream_pkg::data_width-1:0] value);
		@(posedge clock);
		push_data   <= value;
		push_enable <= 1'b1;
		@(posedge clock);
		push_enable <= 1'b0;
	endtask

	// next output handshake, cycles counts the edges it took.
	task automatic wait_transfer(output logic [stream_pkg::data_width-1:0] data,
		output int cycles);
		int waited;
		waited = 0;
		@(posedge clock);
		while (!(out_valid && out_ready))
		begin
			waited++;
			if (waited > transfer_timeout)
				report_failure("no output transfer within the timeout");
			@(posedge clock);
		end
		data   = out_data; // value before the edge.
		cycles = waited + 1;
	endtask

	`include "stream_pipe_tests.svh"

	//////////////////////////////////////////////////////////////
	// test sequence.
	//////////////////////////////////////////////////////////////

	initial
	begin
		resetn      <= 1'b0;
		mode        <= stream_pkg::mode_push;
		push_data   <= '0;
		push_enable <= 1'b0;
		out_ready   <= 1'b0;
		apply_reset();
		test_reset_state();
		test_push_order();
		test_back_pressure(); // ends with a reset to clear error.
		test_count_mode();
		test_throttle_spacing();
		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
+incdir+tb
src/stream_pkg.sv
src/stream_source.sv
src/stream_register_slice.sv
src/stream_fifo.sv
src/stream_throttle.sv
src/stream_pipe_top.sv
tb/stream_pipe_tb.sv

//--- Makefile
# Verilator build and run of the byte stream pipeline testbench.

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= stream_pipe_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search the log for the pass message"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
